//--- Bender.yml
package:
  name: uart

export_include_dirs:
  - rtl

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/uart_rx_fifo.sv
  - rtl/uart_wb_regs.sv
  - rtl/uart_top.sv
  - target: test
    files:
      - tb/uart_sva.sv
      - tb/uart_tb.sv

//--- flist.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_rx_fifo.sv
rtl/uart_wb_regs.sv
rtl/uart_top.sv
tb/uart_sva.sv
tb/uart_tb.sv

//--- rtl/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Clock cycles per serial bit is clk frequency over baud rate
// 16 keeps simulation short while 434 suits 50 MHz at 115200
`define UART_CLKS_PER_BIT 16

// Receive FIFO entries
`define UART_RX_FIFO_DEPTH 8

// Register word addresses
`define UART_ADDR_DATA   0  // Write sends a byte and read pops the receive FIFO
`define UART_ADDR_STATUS 1  // Read gives status and any write clears the sticky flags

// STATUS layout
//   bit 0  rx_empty
//   bit 1  rx_full
//   bit 2  tx_busy
//   bit 3  frame_err (sticky)
//   bit 4  overrun (sticky)
//   bits 7..5 read as zero

`endif

//--- rtl/uart_pkg.sv
package uart_pkg;

  typedef logic [7:0]  uart_byte_t;  // One serial character
  typedef logic [1:0]  reg_addr_t;   // Register word address
  typedef logic [15:0] baud_cnt_t;   // Bit period counter

  // Bus master to slave
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    reg_addr_t  adr;
    uart_byte_t dat;
  } wb_req_t;

  // Slave to bus master
  typedef struct packed {
    logic       ack;
    uart_byte_t dat;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    rxs_idle, rxs_start, rxs_data, rxs_stop, rxs_cleanup
  } rx_state_t;

  typedef enum logic [1:0] {
    txs_idle, txs_start, txs_data, txs_stop
  } tx_state_t;

endpackage

//--- rtl/uart_rx.sv
`include "uart_cfg.svh"

module uart_rx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 rxd,           // Asynchronous serial line
  output logic                 rx_valid,      // One cycle per received frame
  output logic                 rx_push,       // Same pulse for good frames only
  output logic                 rx_frame_err,  // Stop bit was low
  output uart_pkg::uart_byte_t rx_data
);
  import uart_pkg::*;

  localparam baud_cnt_t mid_cnt  = baud_cnt_t'((clks_per_bit - 1) / 2);
  localparam baud_cnt_t last_cnt = baud_cnt_t'(clks_per_bit - 1);

  logic       rxd_meta;
  logic       rxd_sync;
  rx_state_t  state;
  baud_cnt_t  cnt;
  logic [2:0] bit_idx;  // Next data bit, LSB first
  uart_byte_t rx_byte;
  logic       bit_end;  // One full bit period since last sample

  assign bit_end = (cnt == last_cnt);
  assign rx_data = rx_byte;

  // Two-flop synchronizer resets to line idle so no false start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= rxs_idle;
      cnt          <= '0;
      bit_idx      <= '0;
      rx_valid     <= 1'b0;
      rx_push      <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      case (state)
        rxs_idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!rxd_sync) state <= rxs_start;  // Falling edge marks a candidate start
        end
        // Start bit must still be low at its middle
        rxs_start: begin
          if (cnt == mid_cnt) begin
            cnt   <= '0;                                 // Now aligned to mid-bit
            state <= rxd_sync ? rxs_idle : rxs_data;     // Glitch rejected
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rxs_data: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= rxs_stop;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rxs_stop: begin
          if (bit_end) begin
            rx_valid     <= 1'b1;
            rx_push      <= rxd_sync;   // Only a high stop bit is a good byte
            rx_frame_err <= !rxd_sync;
            cnt          <= '0;
            state        <= rxs_cleanup;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rxs_cleanup: begin  // Strobes last one cycle
          rx_valid     <= 1'b0;
          rx_push      <= 1'b0;
          rx_frame_err <= 1'b0;
          state        <= rxs_idle;
        end
        default: state <= rxs_idle;
      endcase
    end
  end

  // Data capture at mid-bit
  always_ff @(posedge clk) begin
    if (state == rxs_data && bit_end) rx_byte[bit_idx] <= rxd_sync;
  end

endmodule

//--- rtl/uart_rx_fifo.sv
`include "uart_cfg.svh"

module uart_rx_fifo (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 push,
  input  logic                 pop,
  input  uart_pkg::uart_byte_t wr_data,
  output uart_pkg::uart_byte_t rd_data,
  output logic                 empty,
  output logic                 full,
  output logic                 overflow  // Pulses when a push while full drops a byte
);
  import uart_pkg::*;

  localparam int depth = `UART_RX_FIFO_DEPTH;
  localparam int aw    = $clog2(depth);

  uart_byte_t      mem [depth];
  logic [aw-1:0]   wr_ptr;
  logic [aw-1:0]   rd_ptr;
  logic [aw:0]     count;
  logic            do_push;
  logic            do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (aw + 1)'(depth));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;  // Pop on empty ignored
  assign rd_data = mem[rd_ptr];    // Head with no read latency

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= push && full;
      if (do_push) wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (aw + 1)'(do_push) - (aw + 1)'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wr_data;
  end

endmodule

//--- rtl/uart_top.sv
module uart_top (
  input  logic              clk,
  input  logic              arst_n,
  input  uart_pkg::wb_req_t wb_req,
  output uart_pkg::wb_rsp_t wb_rsp,
  input  logic              rxd,
  output logic              txd
);
  import uart_pkg::*;

  logic       rx_valid;
  logic       rx_push;      // Good bytes only, feeds the FIFO
  logic       rx_frame_err;
  uart_byte_t rx_data;
  uart_byte_t fifo_rd_data;
  logic       empty;
  logic       full;
  logic       overflow;
  logic       pop;          // DATA read consumed the head
  logic       tx_valid;
  logic       tx_ready;
  uart_byte_t tx_data;

  uart_rx u_rx (.clk(clk), .arst_n(arst_n), .rxd(rxd), .rx_valid(rx_valid),
                .rx_push(rx_push), .rx_frame_err(rx_frame_err), .rx_data(rx_data));

  uart_rx_fifo u_fifo (.clk(clk), .arst_n(arst_n), .push(rx_push), .pop(pop),
                       .wr_data(rx_data), .rd_data(fifo_rd_data), .empty(empty),
                       .full(full), .overflow(overflow));

  uart_wb_regs u_regs (.clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
                       .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
                       .pop(pop), .rd_data(fifo_rd_data), .empty(empty), .full(full),
                       .overflow(overflow), .rx_frame_err(rx_frame_err),
                       .rx_valid(rx_valid));

  uart_tx u_tx (.clk(clk), .arst_n(arst_n), .tx_valid(tx_valid), .tx_data(tx_data),
                .tx_ready(tx_ready), .txd(txd));

endmodule

//--- rtl/uart_tx.sv
`include "uart_cfg.svh"

module uart_tx #(
  parameter int clks_per_bit = `UART_CLKS_PER_BIT
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 tx_valid,
  input  uart_pkg::uart_byte_t tx_data,
  output logic                 tx_ready,  // High in idle only
  output logic                 txd
);
  import uart_pkg::*;

  localparam baud_cnt_t last_cnt = baud_cnt_t'(clks_per_bit - 1);

  tx_state_t  state;
  baud_cnt_t  cnt;
  logic [2:0] bit_idx;
  uart_byte_t shift;     // Remaining data bits with the LSB next out
  logic       bit_end;   // Last cycle of the current bit
  logic       load;

  assign tx_ready = (state == txs_idle);
  assign load     = tx_valid && tx_ready;
  assign bit_end  = (cnt == last_cnt);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= txs_idle;
      cnt     <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;  // Line idles high
    end else begin
      case (state)
        txs_idle: begin
          cnt     <= '0;
          bit_idx <= '0;
          txd     <= !load;  // Start bit begins the cycle after acceptance
          if (load) state <= txs_start;
        end
        txs_start: begin
          cnt <= bit_end ? '0 : cnt + 1'b1;
          if (bit_end) begin
            txd   <= shift[0];
            state <= txs_data;
          end
        end
        txs_data: begin
          cnt <= bit_end ? '0 : cnt + 1'b1;
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            txd     <= (bit_idx == 3'd7) ? 1'b1 : shift[0];  // Stop bit after bit 7
            if (bit_idx == 3'd7) state <= txs_stop;
          end
        end
        txs_stop: begin
          cnt <= bit_end ? '0 : cnt + 1'b1;
          if (bit_end) state <= txs_idle;  // Full stop bit sent
        end
        default: state <= txs_idle;
      endcase
    end
  end

  // Shifter advances each time a bit goes onto the line
  always_ff @(posedge clk) begin
    if (load) shift <= tx_data;
    else if (bit_end && (state == txs_start || state == txs_data)) shift <= shift >> 1;
  end

endmodule

//--- rtl/uart_wb_regs.sv
`include "uart_cfg.svh"

module uart_wb_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  uart_pkg::wb_req_t    wb_req,
  output uart_pkg::wb_rsp_t    wb_rsp,
  output logic                 tx_valid,
  output uart_pkg::uart_byte_t tx_data,
  input  logic                 tx_ready,
  output logic                 pop,
  input  uart_pkg::uart_byte_t rd_data,
  input  logic                 empty,
  input  logic                 full,
  input  logic                 overflow,
  input  logic                 rx_frame_err,
  input  logic                 rx_valid
);
  import uart_pkg::*;

  logic       req;        // Bus cycle in progress
  logic       sel_data;
  logic       sel_status;
  logic       data_wr;
  logic       issue;      // Ack goes out next cycle
  logic       ack_q;
  logic       pop_q;      // DATA read latched a byte from the head
  uart_byte_t rdat_q;
  uart_byte_t status;
  logic       frame_err_q;
  logic       overrun_q;
  logic       clr_sticky;

  assign req        = wb_req.cyc && wb_req.stb;
  assign sel_data   = (wb_req.adr == reg_addr_t'(`UART_ADDR_DATA));
  assign sel_status = (wb_req.adr == reg_addr_t'(`UART_ADDR_STATUS));
  assign data_wr    = req && wb_req.we && sel_data;

  // Byte offered to transmitter until it is taken; !ack_q stops a repeat
  assign tx_valid = data_wr && !ack_q;
  assign tx_data  = wb_req.dat;

  // DATA writes stall on a busy transmitter while everything else acks at once
  assign issue      = req && !ack_q && (!data_wr || tx_ready);
  assign clr_sticky = issue && wb_req.we && sel_status;

  // Pop lands on the ack cycle and only for a read that returned a byte
  assign pop = pop_q;

  assign status = {3'b000, overrun_q, frame_err_q, !tx_ready, full, empty};

  assign wb_rsp = '{ack: ack_q, dat: rdat_q};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q       <= 1'b0;
      pop_q       <= 1'b0;
      frame_err_q <= 1'b0;
      overrun_q   <= 1'b0;
    end else begin
      ack_q <= issue;
      pop_q <= issue && !wb_req.we && sel_data && !empty;
      // New events win over a clear in the same cycle
      if (rx_valid && rx_frame_err) frame_err_q <= 1'b1;
      else if (clr_sticky)          frame_err_q <= 1'b0;
      if (overflow)        overrun_q <= 1'b1;
      else if (clr_sticky) overrun_q <= 1'b0;
    end
  end

  // Read mux is registered so data is valid with ack
  always_ff @(posedge clk) begin
    if (issue) begin
      if (sel_data)        rdat_q <= empty ? '0 : rd_data;  // Empty reads zero
      else if (sel_status) rdat_q <= status;
      else                 rdat_q <= '0;                    // Unmapped
    end
  end

endmodule

//--- tb/uart_sva.sv
module uart_sva (
  input logic              clk,
  input logic              arst_n,
  input uart_pkg::wb_req_t wb_req,
  input uart_pkg::wb_rsp_t wb_rsp,
  input logic              txd,
  input logic              tx_ready,
  input logic              empty,
  input logic              full
);
  int unsigned fail_cnt = 0;  // Failed assertions so far

  // Single-cycle ack per transfer
  ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ack high for two cycles in a row");
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(wb_rsp.ack) |-> wb_req.cyc && wb_req.stb)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ack rose outside a bus cycle");
    end

  // Idle transmitter keeps the line high
  txd_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
    tx_ready |-> txd)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("txd low while transmitter idle");
    end

  fifo_flags: assert property (@(posedge clk) disable iff (!arst_n) !(empty && full))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FIFO empty and full at once");
    end

endmodule

bind uart_top uart_sva uart_sva_inst (.clk(clk), .arst_n(arst_n), .wb_req(wb_req),
  .wb_rsp(wb_rsp), .txd(txd), .tx_ready(tx_ready), .empty(empty), .full(full));

//--- tb/uart_tb.sv
`include "uart_cfg.svh"

module uart_tb;
  import uart_pkg::*;

  localparam int        clks_per_bit = `UART_CLKS_PER_BIT;
  localparam int        limit        = 40 * 10 * clks_per_bit + 2000;  // 40 characters plus margin
  localparam reg_addr_t addr_data    = reg_addr_t'(`UART_ADDR_DATA);
  localparam reg_addr_t addr_status  = reg_addr_t'(`UART_ADDR_STATUS);
  localparam uart_byte_t st_rx_empty  = 8'h01;  // STATUS bits
  localparam uart_byte_t st_rx_full   = 8'h02;
  localparam uart_byte_t st_tx_busy   = 8'h04;
  localparam uart_byte_t st_frame_err = 8'h08;
  localparam uart_byte_t st_overrun   = 8'h10;

  logic    clk;
  logic    arst_n;
  logic    rxd;
  logic    txd;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  int      errors;
  int      cycle_cnt;  // Rising edges so far
  int      ack_cycle;  // Edge of the last ack

  uart_top uart_top_inst (.clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
                          .rxd(rxd), .txd(txd));

  initial clk = 1'b0;
  always #10 clk = ~clk;

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < limit) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout, tests still running after %0d clock cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input uart_byte_t got, input uart_byte_t exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[FAIL] %0t: %s after %0d cycles expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // Master holds the request until ack and drops it after the ack edge
  task automatic bus_cycle(input logic we, input reg_addr_t addr, input uart_byte_t wdat,
                           output uart_byte_t rdat);
    @(posedge clk);
    #2;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdat};
    do begin
      @(posedge clk);
      #2;
    end while (!wb_rsp.ack);
    rdat      = wb_rsp.dat;  // Valid with ack
    ack_cycle = cycle_cnt;
    @(posedge clk);
    #2;
    wb_req = '0;
  endtask

  task automatic wb_write(input reg_addr_t addr, input uart_byte_t data);
    uart_byte_t unused;
    bus_cycle(1'b1, addr, data, unused);
  endtask

  task automatic wb_read(input reg_addr_t addr, output uart_byte_t data);
    bus_cycle(1'b0, addr, 8'h00, data);
  endtask

  // Start bit, 8 data bits LSB first and stop bit of clks_per_bit cycles each
  task automatic send_serial(input uart_byte_t data, input logic bad_stop);
    logic [9:0] frame;
    frame = {!bad_stop, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      rxd = frame[i];
      repeat (clks_per_bit - 1) @(posedge clk);
    end
    @(posedge clk);
    #2;
    rxd = 1'b1;
  endtask

  // Finds the start bit and samples every bit at its middle up to the stop bit
  task automatic sample_serial(output uart_byte_t data);
    do begin
      @(posedge clk);
      #2;
    end while (txd !== 1'b0);
    repeat (clks_per_bit / 2) @(posedge clk);
    #2;
    if (txd !== 1'b0) begin
      $display("Start bit on txd ended before its middle at %0t", $time);
      errors++;
    end
    for (int i = 0; i < 9; i++) begin
      repeat (clks_per_bit) @(posedge clk);
      #2;
      if (i < 8) data[i] = txd;
    end
    if (txd !== 1'b1) begin
      $display("Stop bit on txd was low at %0t", $time);
      errors++;
    end
  endtask

  task automatic receive_bytes();
    uart_byte_t data;
    uart_byte_t got;
    repeat (3) begin
      data = uart_byte_t'($urandom);
      send_serial(data, 1'b0);
      wb_read(addr_status, got);
      check_status(got, 8'h00, "status after receive");
      wb_read(addr_data, got);
      check_byte(got, data, "received byte");
    end
    wb_read(addr_status, got);
    check_status(got, st_rx_empty, "status after draining");
  endtask

  task automatic transmit_byte();
    uart_byte_t data;
    uart_byte_t got;
    uart_byte_t st;
    data = uart_byte_t'($urandom);
    fork
      sample_serial(got);
      begin
        wb_write(addr_data, data);
        wb_read(addr_status, st);
        check_status(st, st_rx_empty | st_tx_busy, "status while sending");
      end
    join
    check_byte(got, data, "byte on txd");
    repeat (clks_per_bit / 2) @(posedge clk);  // Rest of the stop bit
    wb_read(addr_status, st);
    check_status(st, st_rx_empty, "status after sending");
  endtask

  // Second DATA write stalls for the whole first frame
  task automatic back_pressure();
    uart_byte_t first;
    uart_byte_t second;
    uart_byte_t got1;
    uart_byte_t got2;
    int         first_ack;
    first  = uart_byte_t'($urandom);
    second = uart_byte_t'($urandom);
    fork
      begin
        sample_serial(got1);
        sample_serial(got2);
      end
      begin
        wb_write(addr_data, first);
        first_ack = ack_cycle;
        wb_write(addr_data, second);
      end
    join
    check_latency(ack_cycle - first_ack, 10 * clks_per_bit + 1, "second ack");
    check_byte(got1, first, "first byte on txd");
    check_byte(got2, second, "second byte on txd");
    repeat (clks_per_bit) @(posedge clk);
  endtask

  task automatic fifo_overrun();
    uart_byte_t sent[$];
    uart_byte_t data;
    uart_byte_t got;
    for (int i = 0; i <= `UART_RX_FIFO_DEPTH; i++) begin  // One byte more than fits
      data = uart_byte_t'($urandom);
      sent.push_back(data);
      send_serial(data, 1'b0);
    end
    wb_read(addr_status, got);
    check_status(got, st_rx_full | st_overrun, "status on overrun");
    for (int i = 0; i < `UART_RX_FIFO_DEPTH; i++) begin
      wb_read(addr_data, got);
      check_byte(got, sent[i], "FIFO byte");
    end
    wb_read(addr_status, got);
    check_status(got, st_rx_empty | st_overrun, "status after draining FIFO");
  endtask

  task automatic framing_error();
    uart_byte_t got;
    send_serial(uart_byte_t'($urandom), 1'b1);
    wb_read(addr_status, got);
    // Overrun still held from the FIFO test
    check_status(got, st_rx_empty | st_frame_err | st_overrun, "status on frame error");
    wb_read(addr_data, got);
    check_byte(got, 8'h00, "DATA read while empty");
  endtask

  task automatic clear_flags();
    uart_byte_t data;
    uart_byte_t got;
    wb_write(addr_status, uart_byte_t'($urandom));  // Any value clears
    wb_read(addr_status, got);
    check_status(got, st_rx_empty, "status after clear");
    data = uart_byte_t'($urandom);
    send_serial(data, 1'b0);
    wb_read(addr_status, got);
    check_status(got, 8'h00, "status after good byte");
    wb_read(addr_data, got);
    check_byte(got, data, "byte after clear");
  endtask

  initial begin
    uart_byte_t got;
    errors = 0;
    arst_n = 1'b0;
    rxd    = 1'b1;  // Line idle
    wb_req = '0;
    void'($urandom(71205));
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    if (txd !== 1'b1) begin
      $display("txd not idle high after reset at %0t", $time);
      errors++;
    end
    wb_read(addr_status, got);
    check_status(got, st_rx_empty, "status after reset");
    receive_bytes();
    transmit_byte();
    back_pressure();
    fifo_overrun();
    framing_error();
    clear_flags();
    $display("Errors: %0d check, %0d assertion", errors, uart_top_inst.uart_sva_inst.fail_cnt);
    if (errors == 0 && uart_top_inst.uart_sva_inst.fail_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
